// File: verilog/stack_pkg.sv
`default_nettype none

package stack_pkg;

	// stack memory geometry
	localparam int stack_bytes = 512;
	localparam int word_bits = 32;
	localparam int word_bytes = 4;
	// byte address into the stack memory
	localparam int addr_bits = 9;
	// esp needs one more bit, 512 means empty
	localparam int esp_bits = 10;
	// apb address width
	localparam int paddr_bits = 5;

	// esp after reset, stack grows downward from here
	localparam logic [esp_bits-1:0] esp_reset = esp_bits'(stack_bytes);
	// esp step for one push or pop
	localparam logic [esp_bits-1:0] word_step = esp_bits'(word_bytes);
	// highest address a whole word still fits at
	localparam logic [esp_bits-1:0] top_word = esp_bits'(stack_bytes - word_bytes);

	// apb register offsets
	localparam logic [paddr_bits-1:0] reg_data = 5'h00;
	localparam logic [paddr_bits-1:0] reg_addr = 5'h04;
	localparam logic [paddr_bits-1:0] reg_cmd = 5'h08;
	localparam logic [paddr_bits-1:0] reg_esp = 5'h0c;

	// command opcodes, as written to CMD
	typedef enum logic [2:0] {
		op_nop = 3'd0,
		op_push = 3'd1,
		op_pop = 3'd2,
		op_store_at = 3'd3,
		op_load_at = 3'd4,
		op_set_esp = 3'd5
	} stack_op;

	// engine sequencer states
	typedef enum logic {
		st_idle = 1'b0,
		st_exec = 1'b1
	} engine_state;

endpackage

`default_nettype wire

// File: verilog/stack_memory.sv
`default_nettype none

module stack_memory (
	input logic clock_4,
	// word write port
	input logic wr_en,
	input logic [stack_pkg::addr_bits-1:0] wr_addr,
	input logic [stack_pkg::word_bits-1:0] wr_data,
	// read port a, follows esp
	input logic [stack_pkg::addr_bits-1:0] rd_a_addr,
	output logic [stack_pkg::word_bits-1:0] rd_a_data,
	// read port b, absolute address
	input logic [stack_pkg::addr_bits-1:0] rd_b_addr,
	output logic [stack_pkg::word_bits-1:0] rd_b_data
);

	// byte wide storage, one byte per address
	logic [7:0] mem [0:stack_pkg::stack_bytes-1];

	// address of byte n of the word at base
	function automatic logic [stack_pkg::addr_bits-1:0] lane(
		input logic [stack_pkg::addr_bits-1:0] base,
		input int n
	);
		lane = base + stack_pkg::addr_bits'(n);
	endfunction

	// little endian word from four bytes at base
	function automatic logic [stack_pkg::word_bits-1:0] gather(
		input logic [stack_pkg::addr_bits-1:0] base
	);
		logic [stack_pkg::word_bits-1:0] w;
		w = '0;
		for (int i = 0; i < stack_pkg::word_bytes; i++) begin
			// lowest address holds the lowest byte
			w[8*i +: 8] = mem[lane(base, i)];
		end
		gather = w;
	endfunction

	// write all four bytes on the executing edge
	always_ff @(posedge clock_4) begin
		if (wr_en) begin
			for (int i = 0; i < stack_pkg::word_bytes; i++) begin
				mem[lane(wr_addr, i)] <= wr_data[8*i +: 8];
			end
		end
	end

	// esp port, used by pop
	always_comb begin
		rd_a_data = gather(rd_a_addr);
	end

	// absolute port, used by load_at
	always_comb begin
		rd_b_data = gather(rd_b_addr);
	end

	// engine fault checks must keep every write inside the array
	write_in_range: assert property (
		@(posedge clock_4) wr_en |-> ({1'b0, wr_addr} <= stack_pkg::top_word)
	) else $error("stack_memory: word write at %0d runs past the last byte", wr_addr);

endmodule

`default_nettype wire

// File: verilog/stack_engine.sv
`default_nettype none

module stack_engine (
	input logic clock_4,
	input logic reset,
	// command from the register block
	input logic start,
	input stack_pkg::stack_op op,
	input logic [stack_pkg::word_bits-1:0] data,
	input logic [stack_pkg::addr_bits-1:0] addr,
	// completion back to the register block
	output logic done,
	output logic fault,
	output logic [stack_pkg::word_bits-1:0] result,
	output logic result_valid,
	output logic [stack_pkg::esp_bits-1:0] esp,
	// memory write port
	output logic wr_en,
	output logic [stack_pkg::addr_bits-1:0] wr_addr,
	output logic [stack_pkg::word_bits-1:0] wr_data,
	// memory read ports
	output logic [stack_pkg::addr_bits-1:0] rd_a_addr,
	input logic [stack_pkg::word_bits-1:0] rd_a_data,
	output logic [stack_pkg::addr_bits-1:0] rd_b_addr,
	input logic [stack_pkg::word_bits-1:0] rd_b_data
);

	stack_pkg::engine_state state;

	// fault for the command now at the inputs
	logic bad;
	// command accepted on this edge
	logic go;
	// esp after a push
	logic [stack_pkg::esp_bits-1:0] esp_dec;

	assign go = start && (state == stack_pkg::st_idle);
	assign esp_dec = esp - stack_pkg::word_step;

	// fault rules per opcode
	always_comb begin
		case (op)
			stack_pkg::op_push: begin
				// no room for another word below esp
				bad = esp < stack_pkg::word_step;
			end
			stack_pkg::op_pop: begin
				// nothing on the stack
				bad = esp > stack_pkg::top_word;
			end
			stack_pkg::op_store_at, stack_pkg::op_load_at: begin
				// unaligned is fine, only the end of memory counts
				bad = {1'b0, addr} > stack_pkg::top_word;
			end
			stack_pkg::op_set_esp: begin
				bad = (data[1:0] != 2'b00) ||
					(data[stack_pkg::word_bits-1:stack_pkg::esp_bits] != '0) ||
					(data[stack_pkg::esp_bits-1:0] > stack_pkg::esp_reset);
			end
			default: begin
				// nop and unknown codes just complete
				bad = 1'b0;
			end
		endcase
	end

	// write only for push and store_at without fault
	assign wr_en = go && !bad &&
		((op == stack_pkg::op_push) || (op == stack_pkg::op_store_at));
	// push writes below esp, store_at at addr
	assign wr_addr = (op == stack_pkg::op_push) ? esp_dec[stack_pkg::addr_bits-1:0] : addr;
	assign wr_data = data;

	// pop reads at esp, load_at at addr
	assign rd_a_addr = esp[stack_pkg::addr_bits-1:0];
	assign rd_b_addr = addr;

	// done is the one cycle spent in st_exec
	assign done = (state == stack_pkg::st_exec);

	// sequencer, esp and completion flags
	always_ff @(posedge clock_4) begin
		if (reset) begin
			state <= stack_pkg::st_idle;
			esp <= stack_pkg::esp_reset;
			fault <= 1'b0;
			result_valid <= 1'b0;
		end else begin
			case (state)
				stack_pkg::st_idle: begin
					if (start) begin
						state <= stack_pkg::st_exec;
						fault <= bad;
						result_valid <= !bad &&
							((op == stack_pkg::op_pop) || (op == stack_pkg::op_load_at));
						if (!bad) begin
							case (op)
								stack_pkg::op_push: esp <= esp_dec;
								stack_pkg::op_pop: esp <= esp + stack_pkg::word_step;
								stack_pkg::op_set_esp: esp <= data[stack_pkg::esp_bits-1:0];
								default: esp <= esp;
							endcase
						end
					end
				end
				default: begin
					// back to idle after the done cycle
					state <= stack_pkg::st_idle;
					fault <= 1'b0;
					result_valid <= 1'b0;
				end
			endcase
		end
	end

	// popped or loaded word, taken from the ports before esp moves
	always_ff @(posedge clock_4) begin
		if (go && !bad) begin
			if (op == stack_pkg::op_pop) begin
				result <= rd_a_data;
			end else if (op == stack_pkg::op_load_at) begin
				result <= rd_b_data;
			end
		end
	end

	// esp only ever holds a legal word boundary
	esp_legal: assert property (
		@(posedge clock_4) disable iff (reset)
		(esp[1:0] == 2'b00) && (esp <= stack_pkg::esp_reset)
	) else $error("stack_engine: esp %0d is unaligned or past the top", esp);

	// one command in flight, done exactly one cycle after start
	done_after_start: assert property (
		@(posedge clock_4) disable iff (reset) done == $past(start)
	) else $error("stack_engine: done does not follow start by one cycle");

endmodule

`default_nettype wire

// File: verilog/stack_apb_regs.sv
`default_nettype none

module stack_apb_regs (
	input logic clock_4,
	input logic reset,
	// apb slave side
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [stack_pkg::paddr_bits-1:0] paddr,
	input logic [stack_pkg::word_bits-1:0] pwdata,
	output logic [stack_pkg::word_bits-1:0] prdata,
	output logic pready,
	output logic pslverr,
	// command to the engine
	output logic start,
	output stack_pkg::stack_op op,
	output logic [stack_pkg::word_bits-1:0] data,
	output logic [stack_pkg::addr_bits-1:0] addr,
	// completion from the engine
	input logic done,
	input logic fault,
	input logic [stack_pkg::word_bits-1:0] result,
	input logic result_valid,
	input logic [stack_pkg::esp_bits-1:0] esp
);

	// pready register, raised one cycle ahead
	logic pready_q;
	// last opcode launched, read back through CMD
	stack_pkg::stack_op cmd_q;

	logic setup;
	logic access;
	logic cmd_wr;
	logic reg_wr;

	assign setup = psel && !penable;
	assign access = psel && penable;
	// transfer is a write to CMD
	assign cmd_wr = pwrite && (paddr == stack_pkg::reg_cmd);
	// plain write completes in its first access cycle
	assign reg_wr = access && pready_q && pwrite;

	// launch in the first access cycle of a CMD write
	assign start = access && cmd_wr && !pready_q;

	// opcode decode, anything unknown becomes nop
	always_comb begin
		op = stack_pkg::op_nop;
		if (pwdata[stack_pkg::word_bits-1:3] == '0) begin
			case (pwdata[2:0])
				3'd1: op = stack_pkg::op_push;
				3'd2: op = stack_pkg::op_pop;
				3'd3: op = stack_pkg::op_store_at;
				3'd4: op = stack_pkg::op_load_at;
				3'd5: op = stack_pkg::op_set_esp;
				default: op = stack_pkg::op_nop;
			endcase
		end
	end

	// wait state generation
	always_ff @(posedge clock_4) begin
		if (reset) begin
			pready_q <= 1'b0;
		end else if (pready_q) begin
			// transfer ends on this edge
			pready_q <= 1'b0;
		end else if (setup) begin
			// zero wait states unless this is a command
			pready_q <= !cmd_wr;
		end else if (start) begin
			// engine executes now, done lands in the next cycle
			pready_q <= 1'b1;
		end
	end

	assign pready = pready_q;
	// error only on a faulting command completion
	assign pslverr = pready_q && done && fault;

	// DATA and ADDR registers, payload only
	always_ff @(posedge clock_4) begin
		if (done && result_valid) begin
			// popped or loaded word replaces DATA
			data <= result;
		end else if (reg_wr && (paddr == stack_pkg::reg_data)) begin
			data <= pwdata;
		end
		if (reg_wr && (paddr == stack_pkg::reg_addr)) begin
			addr <= pwdata[stack_pkg::addr_bits-1:0];
		end
	end

	// last command for read back
	always_ff @(posedge clock_4) begin
		if (reset) begin
			cmd_q <= stack_pkg::op_nop;
		end else if (start) begin
			cmd_q <= op;
		end
	end

	// read mux, unmapped offsets read zero
	always_comb begin
		case (paddr)
			stack_pkg::reg_data: prdata = data;
			stack_pkg::reg_addr: prdata = {{(stack_pkg::word_bits-stack_pkg::addr_bits){1'b0}}, addr};
			stack_pkg::reg_cmd: prdata = {{(stack_pkg::word_bits-3){1'b0}}, cmd_q};
			stack_pkg::reg_esp: prdata = {{(stack_pkg::word_bits-stack_pkg::esp_bits){1'b0}}, esp};
			default: prdata = '0;
		endcase
	end

	// the early pready register must line up with a live access cycle
	pready_in_access: assert property (
		@(posedge clock_4) disable iff (reset) pready |-> (psel && penable)
	) else $error("stack_apb_regs: pready high outside an access cycle");

endmodule

`default_nettype wire

// File: verilog/stack_top.sv
`default_nettype none

module stack_top (
	input logic clock_4,
	input logic reset,
	// apb slave
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [stack_pkg::paddr_bits-1:0] paddr,
	input logic [stack_pkg::word_bits-1:0] pwdata,
	output logic [stack_pkg::word_bits-1:0] prdata,
	output logic pready,
	output logic pslverr
);

	// register block to engine
	logic start;
	stack_pkg::stack_op op;
	logic [stack_pkg::word_bits-1:0] data;
	logic [stack_pkg::addr_bits-1:0] addr;

	// engine back to register block
	logic done;
	logic fault;
	logic [stack_pkg::word_bits-1:0] result;
	logic result_valid;
	logic [stack_pkg::esp_bits-1:0] esp;

	// engine to memory
	logic wr_en;
	logic [stack_pkg::addr_bits-1:0] wr_addr;
	logic [stack_pkg::word_bits-1:0] wr_data;
	logic [stack_pkg::addr_bits-1:0] rd_a_addr;
	logic [stack_pkg::word_bits-1:0] rd_a_data;
	logic [stack_pkg::addr_bits-1:0] rd_b_addr;
	logic [stack_pkg::word_bits-1:0] rd_b_data;

	stack_apb_regs regs_i (
		.clock_4(clock_4), .reset(reset),
		.psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata),
		.prdata(prdata), .pready(pready), .pslverr(pslverr),
		.start(start), .op(op), .data(data), .addr(addr),
		.done(done), .fault(fault),
		.result(result), .result_valid(result_valid),
		.esp(esp)
	);

	stack_engine engine_i (
		.clock_4(clock_4), .reset(reset),
		.start(start), .op(op), .data(data), .addr(addr),
		.done(done), .fault(fault),
		.result(result), .result_valid(result_valid),
		.esp(esp),
		.wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
		.rd_a_addr(rd_a_addr), .rd_a_data(rd_a_data),
		.rd_b_addr(rd_b_addr), .rd_b_data(rd_b_data)
	);

	stack_memory memory_i (
		.clock_4(clock_4),
		.wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
		.rd_a_addr(rd_a_addr), .rd_a_data(rd_a_data),
		.rd_b_addr(rd_b_addr), .rd_b_data(rd_b_data)
	);

endmodule

`default_nettype wire

// File: tests/stack_tb.sv
`default_nettype none

module stack_tb;
	timeunit 1ns;
	timeprecision 100ps;

	logic clock_4;
	logic reset;
	logic psel;
	logic penable;
	logic pwrite;
	logic [stack_pkg::paddr_bits-1:0] paddr;
	logic [stack_pkg::word_bits-1:0] pwdata;
	logic [stack_pkg::word_bits-1:0] prdata;
	logic pready;
	logic pslverr;

	// reference model of memory, stack contents, esp and the DATA/ADDR registers
	logic [7:0] model_mem [0:stack_pkg::stack_bytes-1];
	logic [31:0] model_stack [$];
	int model_esp;
	int model_addr;
	logic [31:0] model_data;
	integer seed;

	stack_top dut_i (
		.clock_4(clock_4), .reset(reset),
		.psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata),
		.prdata(prdata), .pready(pready), .pslverr(pslverr)
	);

	initial begin
		clock_4 = 1'b0;
		forever #50 clock_4 = ~clock_4;
	end

	// print the reason, then end the run as failed
	task automatic stop_run(input string why);
		$display("%s", why);
		$display("=== FAIL ===");
		$fatal(1, "stack_tb stopped on first error");
	endtask

	task automatic compare(input string test, input logic [31:0] expected,
		input logic [31:0] actual);
		string line;
		assert (actual === expected) else begin
			line = $sformatf("[FAIL] %s: expected %h, actual %h", test, expected, actual);
			stop_run(line);
		end
	endtask

	// little endian byte model
	task automatic put_word(input int base, input logic [31:0] w);
		for (int i = 0; i < 4; i++) begin
			model_mem[base + i] = w[8*i +: 8];
		end
	endtask

	function automatic logic [31:0] get_word(input int base);
		logic [31:0] w;
		for (int i = 0; i < 4; i++) begin
			w[8*i +: 8] = model_mem[base + i];
		end
		return w;
	endfunction

	// one apb transfer, setup then access until pready
	task automatic apb_xfer(input logic write, input logic [stack_pkg::paddr_bits-1:0] offset,
		input logic [31:0] wdata, output logic [31:0] rdata, output logic err);
		int waits;
		@(posedge clock_4);
		psel <= 1'b1;
		penable <= 1'b0;
		pwrite <= write;
		paddr <= offset;
		pwdata <= wdata;
		@(posedge clock_4);
		penable <= 1'b1;
		waits = 0;
		// sample on the falling edge, away from the driving edge
		@(negedge clock_4);
		while (!pready) begin
			waits++;
			if (waits > 8) begin
				stop_run("apb transfer timed out waiting for pready");
			end
			@(negedge clock_4);
		end
		rdata = prdata;
		err = pslverr;
		@(posedge clock_4);
		psel <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic write_reg(input string test, input logic [stack_pkg::paddr_bits-1:0] offset,
		input logic [31:0] value, input logic exp_err);
		logic [31:0] ignored;
		logic err;
		apb_xfer(1'b1, offset, value, ignored, err);
		compare({test, " pslverr"}, {31'h0, exp_err}, {31'h0, err});
	endtask

	task automatic check_reg(input string test, input logic [stack_pkg::paddr_bits-1:0] offset,
		input logic [31:0] expected);
		logic [31:0] value;
		logic err;
		apb_xfer(1'b0, offset, 32'h0, value, err);
		compare(test, expected, value);
		compare({test, " pslverr"}, 32'h0, {31'h0, err});
	endtask

	task automatic set_data(input logic [31:0] value);
		write_reg("write DATA", stack_pkg::reg_data, value, 1'b0);
		model_data = value;
	endtask

	task automatic set_addr(input int value);
		write_reg("write ADDR", stack_pkg::reg_addr, 32'(value), 1'b0);
		model_addr = value;
	endtask

	// predict fault and effect from the command rules, then issue it
	task automatic run_cmd(input string test, input logic [31:0] code);
		logic expect_fault;
		expect_fault = 1'b0;
		case (code)
			32'(stack_pkg::op_push): begin
				if (model_esp < 4) begin
					expect_fault = 1'b1;
				end else begin
					model_esp = model_esp - 4;
					put_word(model_esp, model_data);
					model_stack.push_back(model_data);
				end
			end
			32'(stack_pkg::op_pop): begin
				if (model_esp > stack_pkg::stack_bytes - 4) begin
					expect_fault = 1'b1;
				end else begin
					model_data = get_word(model_esp);
					model_esp = model_esp + 4;
					if (model_stack.size() > 0) begin
						void'(model_stack.pop_back());
					end
				end
			end
			32'(stack_pkg::op_store_at): begin
				if (model_addr > stack_pkg::stack_bytes - 4) begin
					expect_fault = 1'b1;
				end else begin
					put_word(model_addr, model_data);
				end
			end
			32'(stack_pkg::op_load_at): begin
				if (model_addr > stack_pkg::stack_bytes - 4) begin
					expect_fault = 1'b1;
				end else begin
					model_data = get_word(model_addr);
				end
			end
			32'(stack_pkg::op_set_esp): begin
				// unaligned or beyond the empty mark
				if ((model_data[1:0] != 2'b00) || (model_data > 32'(stack_pkg::stack_bytes))) begin
					expect_fault = 1'b1;
				end else begin
					model_esp = int'(model_data);
					model_stack.delete();
				end
			end
			default: begin
				// nop or unknown, nothing changes
			end
		endcase
		write_reg(test, stack_pkg::reg_cmd, code, expect_fault);
	endtask

	// CMD: exactly one wait state
	cmd_two_access: assert property (
		@(posedge clock_4) disable iff (reset)
		(psel && !penable && pwrite && (paddr == stack_pkg::reg_cmd)) |=>
			(psel && penable && !pready) ##1 (psel && penable && pready)
	) else stop_run("handshake: CMD transfer did not take exactly two access cycles");

	// register reads and plain writes, zero wait states
	plain_one_access: assert property (
		@(posedge clock_4) disable iff (reset)
		(psel && !penable && !(pwrite && (paddr == stack_pkg::reg_cmd))) |=>
			(psel && penable && pready)
	) else stop_run("handshake: register transfer did not finish in its first access cycle");

	idle_quiet: assert property (
		@(posedge clock_4) disable iff (reset)
		!(psel && penable) |-> (!pready && !pslverr)
	) else stop_run("pready or pslverr high outside an access cycle");

	initial begin
		logic [31:0] expected;
		logic [31:0] kept;
		seed = 32'he990_79f1;
		reset = 1'b1;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		model_esp = stack_pkg::stack_bytes;
		model_addr = 0;
		model_data = '0;
		repeat (10) @(posedge clock_4);
		reset <= 1'b0;

		// state after reset
		check_reg("reset ESP", stack_pkg::reg_esp, 32'(stack_pkg::stack_bytes));
		check_reg("reset CMD", stack_pkg::reg_cmd, 32'h0);

		// lifo order with random words
		for (int i = 0; i < 8; i++) begin
			set_data($random(seed));
			run_cmd("push", 32'(stack_pkg::op_push));
			check_reg("push ESP", stack_pkg::reg_esp, model_esp);
		end
		for (int i = 0; i < 8; i++) begin
			expected = model_stack[$];
			run_cmd("pop", 32'(stack_pkg::op_pop));
			check_reg("pop DATA", stack_pkg::reg_data, expected);
			check_reg("pop ESP", stack_pkg::reg_esp, model_esp);
		end

		// overlapping unaligned stores, load in between
		set_addr('h0a1);
		set_data(32'h1122_3344);
		run_cmd("store_at low", 32'(stack_pkg::op_store_at));
		set_addr('h0a3);
		set_data(32'haabb_ccdd);
		run_cmd("store_at high", 32'(stack_pkg::op_store_at));
		set_addr('h0a2);
		run_cmd("load_at", 32'(stack_pkg::op_load_at));
		check_reg("load_at DATA", stack_pkg::reg_data, model_data);
		check_reg("load_at ESP", stack_pkg::reg_esp, model_esp);

		// overflow, one word of room left
		set_data(32'd4);
		run_cmd("set_esp 4", 32'(stack_pkg::op_set_esp));
		set_data($random(seed));
		kept = model_data;
		run_cmd("push last", 32'(stack_pkg::op_push));
		set_data($random(seed));
		run_cmd("push full", 32'(stack_pkg::op_push));
		check_reg("overflow ESP", stack_pkg::reg_esp, 32'h0);
		check_reg("overflow DATA", stack_pkg::reg_data, model_data);
		set_addr(0);
		run_cmd("overflow memory", 32'(stack_pkg::op_load_at));
		check_reg("overflow memory DATA", stack_pkg::reg_data, kept);
		// a refused push from esp 0 would wrap onto the top word
		set_addr(stack_pkg::stack_bytes - 4);
		run_cmd("overflow top memory", 32'(stack_pkg::op_load_at));
		check_reg("overflow top memory DATA", stack_pkg::reg_data, model_data);

		// underflow on an empty stack
		set_data(32'(stack_pkg::stack_bytes));
		run_cmd("set_esp empty", 32'(stack_pkg::op_set_esp));
		run_cmd("pop empty", 32'(stack_pkg::op_pop));
		check_reg("underflow ESP", stack_pkg::reg_esp, model_esp);
		check_reg("underflow DATA", stack_pkg::reg_data, model_data);

		// absolute access past the last whole word
		set_addr(stack_pkg::stack_bytes - 4);
		set_data(32'h5a5a_0001);
		run_cmd("store_at top", 32'(stack_pkg::op_store_at));
		set_addr(stack_pkg::stack_bytes - 3);
		set_data(32'hdead_beef);
		run_cmd("store_at past top", 32'(stack_pkg::op_store_at));
		run_cmd("load_at past top", 32'(stack_pkg::op_load_at));
		check_reg("past top DATA", stack_pkg::reg_data, model_data);
		check_reg("past top ESP", stack_pkg::reg_esp, model_esp);
		set_addr(stack_pkg::stack_bytes - 4);
		run_cmd("load_at top", 32'(stack_pkg::op_load_at));
		check_reg("top memory DATA", stack_pkg::reg_data, model_data);

		// set_esp legality
		set_data(32'h0000_0102);
		run_cmd("set_esp unaligned", 32'(stack_pkg::op_set_esp));
		set_data(32'd516);
		run_cmd("set_esp too large", 32'(stack_pkg::op_set_esp));
		set_data(32'h0001_0100);
		run_cmd("set_esp high bits", 32'(stack_pkg::op_set_esp));
		check_reg("bad set_esp ESP", stack_pkg::reg_esp, model_esp);
		set_data(32'h0000_0100);
		run_cmd("set_esp legal", 32'(stack_pkg::op_set_esp));
		check_reg("set_esp ESP", stack_pkg::reg_esp, model_esp);
		set_data($random(seed));
		kept = model_data;
		run_cmd("push after set_esp", 32'(stack_pkg::op_push));
		check_reg("push after set_esp ESP", stack_pkg::reg_esp, 32'h0000_00fc);
		set_addr('h0fc);
		run_cmd("load pushed word", 32'(stack_pkg::op_load_at));
		check_reg("pushed word DATA", stack_pkg::reg_data, kept);

		// nop and unknown codes complete quietly
		run_cmd("nop", 32'(stack_pkg::op_nop));
		run_cmd("unknown opcode", 32'h0000_0007);
		run_cmd("opcode with high bits", 32'h0000_0101);
		check_reg("nop ESP", stack_pkg::reg_esp, model_esp);
		check_reg("nop DATA", stack_pkg::reg_data, model_data);

		$display("=== PASS ===");
		$finish;
	end

endmodule

`default_nettype wire

// File: sim.f
verilog/stack_pkg.sv
verilog/stack_memory.sv
verilog/stack_engine.sv
verilog/stack_apb_regs.sv
verilog/stack_top.sv
tests/stack_tb.sv

// File: run.sh
#!/bin/sh
# compile and run the stack testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	--top-module stack_tb \
	-Mdir obj_dir \
	-f sim.f

# $fatal gives a nonzero exit status, which set -e passes on
./obj_dir/Vstack_tb
